// File: Bender.yml
package:
  name: tx_frontend

sources:
  - files:
      - verilog/tx_frontend_pkg.sv
      - verilog/tx_settings_regs.sv
      - verilog/add_clip_reg.sv
      - verilog/iq_compensation.sv
      - verilog/round_sd.sv
      - verilog/tx_frontend.sv
  - target: test
    files:
      - tb/tx_frontend_tb.sv

// File: tb/tx_frontend_tb.sv
//////////////////////////////////////////////////
// testbench for the tx front end.
// LFSR stimulus, wishbone driver and reference model.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tx_frontend_tb;

  logic                           clk = 1'b0;
  logic                           rst;
  logic                           run_i;
  logic                           tx_stb_i;
  tx_frontend_pkg::iq_sample_t    tx_i;
  tx_frontend_pkg::wb_req_t       wb_i;
  tx_frontend_pkg::wb_rsp_t       wb_o;
  logic                           dac_stb_o;
  tx_frontend_pkg::iq_sample_t    dac_o;

  logic [15:0]                    lfsr_q = 16'd48540;
  tx_frontend_pkg::iq_sample_t    expect_q[$];  // expected dac words in order.
  longint                         res_q[2] = '{0, 0};  // model residues for the I and Q rails.
  longint                         sh_dc_i = 0;
  longint                         sh_dc_q = 0;
  longint                         sh_mag = 0;
  longint                         sh_phase = 0;
  logic [3:0]                     sh_mux_i = 4'd0;
  logic [3:0]                     sh_mux_q = 4'd0;
  logic [31:0]                    regs_exp[8] = '{default: 32'd0};
  int                             sent = 0;
  int                             received = 0;

  tx_frontend #(
    .ENABLE_IQ_COMP  (1),
    .ENABLE_DC_OFFSET(1)
  ) tx_frontend_i (
    .clk      (clk),
    .rst      (rst),
    .run_i    (run_i),
    .wb_i     (wb_i),
    .wb_o     (wb_o),
    .tx_stb_i (tx_stb_i),
    .tx_i     (tx_i),
    .dac_stb_o(dac_stb_o),
    .dac_o    (dac_o)
  );

  always #20 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  // galois LFSR stepped once for every bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic longint sext(input logic [31:0] v, input int w);
    longint t;
    t = longint'(v) << (64 - w);
    return t >>> (64 - w);
  endfunction

  function automatic longint sat(input longint v, input int w);
    longint hi;
    longint lo;
    hi = (longint'(1) << (w - 1)) - 1;
    lo = -(longint'(1) << (w - 1));
    return (v > hi) ? hi : ((v < lo) ? lo : v);
  endfunction

  // error feedback carries the cut fraction into the next sample.
  function automatic longint round_rail(input longint x, input int k);
    longint s;
    longint y;
    s = x + res_q[k];
    y = s >>> 8;
    if (y > 32767 || y < -32768) begin
      res_q[k] = 0;  // clipped samples forget their error.
      y = sat(y, 16);
    end else begin
      res_q[k] = s & 255;
    end
    return y;
  endfunction

  function automatic longint pick_rail(input logic [3:0] code, input longint i, input longint q);
    if (code == 4'd0) return i;
    if (code == 4'd1) return q;
    return 0;
  endfunction

  function automatic tx_frontend_pkg::iq_sample_t predict(input longint si, input longint sq);
    tx_frontend_pkg::iq_sample_t o;
    longint wi;
    longint wq;
    longint ri;
    longint rq;
    wi = sat(si * 256 + ((si * 4 * sh_mag) >>> 12), 24);
    wq = sat(sq * 256 + ((si * 4 * sh_phase) >>> 12), 24);
    ri = round_rail(sat(wi + sh_dc_i, 24), 0);
    rq = round_rail(sat(wq + sh_dc_q, 24), 1);
    o.i = pick_rail(sh_mux_i, ri, rq);
    o.q = pick_rail(sh_mux_q, ri, rq);
    return o;
  endfunction

  task automatic wb_access(input logic write, input logic [2:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    @(posedge clk);
    wb_i.cyc <= 1'b1;
    wb_i.stb <= 1'b1;
    wb_i.we  <= write;
    wb_i.adr <= adr;
    wb_i.dat <= wdat;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_o.ack && n < 20);
    assert (wb_o.ack) else stop_with_failure("timeout waiting for the wishbone ack");
    rdat = wb_o.dat;
    @(posedge clk);
    wb_i.cyc <= 1'b0;
    wb_i.stb <= 1'b0;
    wb_i.we  <= 1'b0;
  endtask

  // writes a register and updates the shadow copy that the model uses.
  task automatic write_reg(input logic [2:0] adr, input logic [31:0] d);
    logic [31:0] unused;
    case (adr)
      3'd0: begin
        sh_dc_i = sext(d, 24);
        regs_exp[0] = d & 32'hFF_FFFF;
      end
      3'd1: begin
        sh_dc_q = sext(d, 24);
        regs_exp[1] = d & 32'hFF_FFFF;
      end
      3'd2: begin
        sh_mag = sext(d, 18);
        regs_exp[2] = d & 32'h3_FFFF;
      end
      3'd3: begin
        sh_phase = sext(d, 18);
        regs_exp[3] = d & 32'h3_FFFF;
      end
      3'd4: begin
        sh_mux_i = d[3:0];
        sh_mux_q = d[7:4];
        regs_exp[4] = d & 32'hFF;
      end
      default: ;
    endcase
    wb_access(1'b1, adr, d, unused);
  endtask

  task automatic check_readback();
    logic [31:0] rd;
    for (int a = 0; a < 8; a++) begin
      wb_access(1'b0, a[2:0], 32'h0, rd);
      assert (rd == regs_exp[a]) else stop_with_failure($sformatf(
        "** Error wb_o.dat (adr %0d): expected %h, got %h", a, regs_exp[a], rd));
    end
  endtask

  task automatic drive_stream(input int cycles, input bit gaps, input bit run_gaps);
    logic   stb;
    logic   run;
    longint si;
    longint sq;
    for (int k = 0; k < cycles; k++) begin
      stb = gaps ? (rand_bits(1) != 0) : 1'b1;
      run = run_gaps ? (rand_bits(2) != 0) : 1'b1;
      si  = sext(rand_bits(16), 16);
      sq  = sext(rand_bits(16), 16);
      @(posedge clk);
      tx_stb_i <= stb;
      run_i    <= run;
      tx_i.i   <= si[15:0];
      tx_i.q   <= sq[15:0];
      if (stb && run) begin
        expect_q.push_back(predict(si, sq));
        sent++;
      end
    end
    @(posedge clk);
    tx_stb_i <= 1'b0;
    run_i    <= 1'b1;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (expect_q.size() != 0 && n < 50) begin
      @(negedge clk);
      n++;
    end
    assert (expect_q.size() == 0) else
      stop_with_failure("timeout, expected samples never came out");
  endtask

  always @(negedge clk) begin : monitor
    tx_frontend_pkg::iq_sample_t exp;
    if (!rst && dac_stb_o) begin
      assert (expect_q.size() != 0) else
        stop_with_failure("dac_stb_o pulsed with no sample due");
      exp = expect_q.pop_front();
      received++;
      assert (dac_o.i == exp.i) else stop_with_failure($sformatf(
        "** Error dac_o.i: expected %h, got %h", exp.i, dac_o.i));
      assert (dac_o.q == exp.q) else stop_with_failure($sformatf(
        "** Error dac_o.q: expected %h, got %h", exp.q, dac_o.q));
    end
  end

  initial begin
    logic [7:0]  mux_codes[6];
    int          dc_w;
    int          coef_w;
    logic [2:0]  adr_r;
    logic [31:0] dat_r;
    mux_codes = '{8'h01, 8'h00, 8'h11, 8'hA5, 8'h0C, 8'h10};
    rst      = 1'b1;
    run_i    = 1'b0;
    tx_stb_i = 1'b0;
    tx_i     = '0;
    wb_i     = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    assert (!dac_stb_o && !wb_o.ack) else
      stop_with_failure("dac_stb_o or wb_o.ack is high right after reset");
    assert (dac_o == '0) else stop_with_failure($sformatf(
      "** Error dac_o: expected %h, got %h", 32'h0, dac_o));

    // with reset settings mux_q = 0 puts I on both rails.
    drive_stream(30, 1'b0, 1'b0);
    wait_drain();
    write_reg(3'd4, 32'h10);
    drive_stream(30, 1'b1, 1'b0);
    wait_drain();

    for (int k = 0; k < 24; k++) begin
      adr_r = 3'(rand_bits(3));
      dat_r = rand_bits(32);
      write_reg(adr_r, dat_r);
      if (k % 6 == 5) check_readback();
    end

    // sweep the corrections with narrow and full width settings.
    for (int r = 0; r < 6; r++) begin
      dc_w   = (r % 2) ? 24 : 10;
      coef_w = (r % 3) ? 18 : 8;
      write_reg(3'd0, 32'(sext(rand_bits(dc_w), dc_w)));
      write_reg(3'd1, 32'(sext(rand_bits(dc_w), dc_w)));
      write_reg(3'd2, 32'(sext(rand_bits(coef_w), coef_w)));
      write_reg(3'd3, 32'(sext(rand_bits(coef_w), coef_w)));
      write_reg(3'd4, 32'h10);
      drive_stream(60, r[0], 1'b0);
      wait_drain();
    end
    write_reg(3'd0, 32'h7F_FFFF);  // extreme settings make both rails clip.
    write_reg(3'd1, 32'h80_0000);
    write_reg(3'd2, 32'h1_FFFF);
    write_reg(3'd3, 32'h2_0000);
    drive_stream(60, 1'b0, 1'b0);
    wait_drain();

    write_reg(3'd0, 32'h00_0123);
    write_reg(3'd2, 32'h0_0800);
    for (int m = 0; m < 6; m++) begin
      write_reg(3'd4, {24'h0, mux_codes[m]});
      drive_stream(20, 1'b1, 1'b0);
      wait_drain();
    end

    drive_stream(200, 1'b1, 1'b1);  // run_i toggles under the strobes.
    wait_drain();
    repeat (20) @(posedge clk);

    if (expect_q.size() == 0 && received == sent) begin
      $display("checked %0d samples", received);
      $display(">>> PASS");
      $finish;
    end else begin
      stop_with_failure("sample count differs at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: tx_frontend.f
verilog/tx_frontend_pkg.sv
verilog/tx_settings_regs.sv
verilog/add_clip_reg.sv
verilog/iq_compensation.sv
verilog/round_sd.sv
verilog/tx_frontend.sv
tb/tx_frontend_tb.sv

// File: verilog/add_clip_reg.sv
//////////////////////////////////////////////////
// registered signed adder with saturation.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module add_clip_reg #(
  parameter int WIDTH = 24
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire signed [WIDTH-1:0]  a_i,
  input  wire signed [WIDTH-1:0]  b_i,
  input  wire                     stb_i,
  output logic signed [WIDTH-1:0] sum_o,
  output logic                    stb_o
);

  logic signed [WIDTH:0] sum_full;  // one guard bit catches the overflow.
  logic                  ovf;

  assign sum_full = a_i + b_i;
  assign ovf      = sum_full[WIDTH] != sum_full[WIDTH-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      if (ovf) begin
        // the guard bit holds the true sign of the sum.
        sum_o <= sum_full[WIDTH] ? {1'b1, {(WIDTH-1){1'b0}}} : {1'b0, {(WIDTH-1){1'b1}}};
      end else begin
        sum_o <= sum_full[WIDTH-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/iq_compensation.sv
//////////////////////////////////////////////////
// iq imbalance compensation.
// scales I by mag and phase and adds it onto I and Q.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module iq_compensation #(
  parameter int WORK_WIDTH = 24,
  parameter int COEF_WIDTH = 18
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           stb_i,
  input  tx_frontend_pkg::iq_sample_t   s_i,
  input  wire signed [COEF_WIDTH-1:0]   mag_i,
  input  wire signed [COEF_WIDTH-1:0]   phase_i,
  output logic                          stb_o,
  output tx_frontend_pkg::iq_work_t     s_o
);

  localparam int X4_W       = tx_frontend_pkg::SAMPLE_W + 2;
  localparam int PROD_W     = X4_W + COEF_WIDTH;
  localparam int PROD_SHIFT = PROD_W - WORK_WIDTH;  // 12 for the default widths.
  localparam int PAD_W      = WORK_WIDTH - tx_frontend_pkg::SAMPLE_W;

  logic signed [X4_W-1:0]       i_x4;
  logic signed [PROD_W-1:0]     mag_prod_q;
  logic signed [PROD_W-1:0]     phase_prod_q;
  tx_frontend_pkg::iq_sample_t  s_d;
  logic                         stb_d;
  logic signed [WORK_WIDTH-1:0] i_shl;
  logic signed [WORK_WIDTH-1:0] q_shl;
  logic signed [WORK_WIDTH-1:0] mag_corr;
  logic signed [WORK_WIDTH-1:0] phase_corr;
  logic signed [WORK_WIDTH-1:0] sum_i;
  logic signed [WORK_WIDTH-1:0] sum_q;

  assign i_x4 = {s_i.i, 2'b00};

  // the first stage registers the products and delays the sample to match.
  always_ff @(posedge clk) begin
    if (stb_i) begin
      mag_prod_q   <= i_x4 * mag_i;
      phase_prod_q <= i_x4 * phase_i;
      s_d          <= s_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stb_d <= 1'b0;
    end else begin
      stb_d <= stb_i;
    end
  end

  // keeping the top bits of a product is its arithmetic shift right.
  assign mag_corr   = mag_prod_q[PROD_W-1:PROD_SHIFT];
  assign phase_corr = phase_prod_q[PROD_W-1:PROD_SHIFT];
  assign i_shl      = {s_d.i, {PAD_W{1'b0}}};  // sample with 8 fraction bits.
  assign q_shl      = {s_d.q, {PAD_W{1'b0}}};

  add_clip_reg #(
    .WIDTH(WORK_WIDTH)
  ) add_i (
    .clk  (clk),
    .rst  (rst),
    .a_i  (i_shl),
    .b_i  (mag_corr),
    .stb_i(stb_d),
    .sum_o(sum_i),
    .stb_o(stb_o)
  );

  // Q gets the phase term and shares the I adder's strobe.
  add_clip_reg #(
    .WIDTH(WORK_WIDTH)
  ) add_q (
    .clk  (clk),
    .rst  (rst),
    .a_i  (q_shl),
    .b_i  (phase_corr),
    .stb_i(stb_d),
    .sum_o(sum_q),
    .stb_o()
  );

  assign s_o = '{i: sum_i, q: sum_q};

  stb_two_cycles: assert property (
    @(posedge clk) disable iff (rst)
    stb_o == $past(stb_i, 2)
  );

endmodule

`default_nettype wire

// File: verilog/round_sd.sv
//////////////////////////////////////////////////
// error feedback rounding to the dac width.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module round_sd #(
  parameter int WIDTH_IN  = 24,
  parameter int WIDTH_OUT = 16
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         stb_i,
  input  wire signed [WIDTH_IN-1:0]   in_i,
  output logic                        stb_o,
  output logic signed [WIDTH_OUT-1:0] out_o
);

  localparam int DIFF = WIDTH_IN - WIDTH_OUT;

  logic [DIFF-1:0]             residue_q;  // dropped fraction of the last sample.
  logic signed [WIDTH_IN:0]    sum;
  logic signed [WIDTH_OUT:0]   shifted;
  logic                        ovf;

  assign sum     = in_i + $signed({1'b0, residue_q});
  assign shifted = sum[WIDTH_IN:DIFF];
  assign ovf     = shifted[WIDTH_OUT] != shifted[WIDTH_OUT-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      stb_o     <= 1'b0;
      residue_q <= '0;
    end else begin
      stb_o <= stb_i;
      if (stb_i) begin
        // a clipped sample carries no error forward.
        residue_q <= ovf ? '0 : sum[DIFF-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stb_i) begin
      if (ovf) begin
        out_o <= shifted[WIDTH_OUT] ? {1'b1, {(WIDTH_OUT-1){1'b0}}}
                                    : {1'b0, {(WIDTH_OUT-1){1'b1}}};
      end else begin
        out_o <= shifted[WIDTH_OUT-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/tx_frontend.sv
//////////////////////////////////////////////////
// transmit front end top level.
// iq and dc correction, rounding and dac rail select.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tx_frontend #(
  parameter int ENABLE_IQ_COMP   = 1,
  parameter int ENABLE_DC_OFFSET = 1
) (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           run_i,
  input  tx_frontend_pkg::wb_req_t      wb_i,
  output tx_frontend_pkg::wb_rsp_t      wb_o,
  input  wire                           tx_stb_i,
  input  tx_frontend_pkg::iq_sample_t   tx_i,
  output logic                          dac_stb_o,
  output tx_frontend_pkg::iq_sample_t   dac_o
);

  localparam int SAMPLE_W = tx_frontend_pkg::SAMPLE_W;
  localparam int WORK_W   = tx_frontend_pkg::WORK_W;
  localparam int CORR_W   = tx_frontend_pkg::CORR_W;

  tx_frontend_pkg::tx_corr_cfg_t cfg;
  logic                          in_stb;
  logic                          comp_stb;
  tx_frontend_pkg::iq_work_t     comp;
  logic                          ofs_stb;
  tx_frontend_pkg::iq_work_t     ofs;
  logic                          rnd_stb;
  logic signed [SAMPLE_W-1:0]    rnd_i;
  logic signed [SAMPLE_W-1:0]    rnd_q;

  // picks the rail for one dac output.
  function automatic logic signed [SAMPLE_W-1:0] sel_rail(
    input logic [tx_frontend_pkg::SEL_W-1:0] code,
    input logic signed [SAMPLE_W-1:0]        i,
    input logic signed [SAMPLE_W-1:0]        q
  );
    case (code)
      tx_frontend_pkg::SEL_I: sel_rail = i;
      tx_frontend_pkg::SEL_Q: sel_rail = q;
      default:                sel_rail = '0;
    endcase
  endfunction

  tx_settings_regs settings (
    .clk  (clk),
    .rst  (rst),
    .wb_i (wb_i),
    .wb_o (wb_o),
    .cfg_o(cfg)
  );

  assign in_stb = tx_stb_i & run_i;  // samples are only taken while running.

  generate
    if (ENABLE_IQ_COMP == 1) begin : g_iq_comp
      iq_compensation #(
        .WORK_WIDTH(WORK_W),
        .COEF_WIDTH(CORR_W)
      ) iq_comp (
        .clk    (clk),
        .rst    (rst),
        .stb_i  (in_stb),
        .s_i    (tx_i),
        .mag_i  (cfg.mag),
        .phase_i(cfg.phase),
        .stb_o  (comp_stb),
        .s_o    (comp)
      );
    end else begin : g_no_iq_comp
      assign comp_stb = in_stb;
      assign comp = '{i: {tx_i.i, {(WORK_W-SAMPLE_W){1'b0}}},
                      q: {tx_i.q, {(WORK_W-SAMPLE_W){1'b0}}}};
    end
  endgenerate

  generate
    if (ENABLE_DC_OFFSET == 1) begin : g_dc_offset
      add_clip_reg #(
        .WIDTH(WORK_W)
      ) add_dc_i (
        .clk  (clk),
        .rst  (rst),
        .a_i  (comp.i),
        .b_i  (cfg.dc_i),
        .stb_i(comp_stb),
        .sum_o(ofs.i),
        .stb_o(ofs_stb)
      );

      add_clip_reg #(
        .WIDTH(WORK_W)
      ) add_dc_q (
        .clk  (clk),
        .rst  (rst),
        .a_i  (comp.q),
        .b_i  (cfg.dc_q),
        .stb_i(comp_stb),
        .sum_o(ofs.q),
        .stb_o()
      );
    end else begin : g_no_dc_offset
      assign ofs_stb = comp_stb;
      assign ofs     = comp;
    end
  endgenerate

  // each rail keeps its own rounding residue.
  round_sd #(
    .WIDTH_IN (WORK_W),
    .WIDTH_OUT(SAMPLE_W)
  ) round_i (
    .clk  (clk),
    .rst  (rst),
    .stb_i(ofs_stb),
    .in_i (ofs.i),
    .stb_o(rnd_stb),
    .out_o(rnd_i)
  );

  round_sd #(
    .WIDTH_IN (WORK_W),
    .WIDTH_OUT(SAMPLE_W)
  ) round_q (
    .clk  (clk),
    .rst  (rst),
    .stb_i(ofs_stb),
    .in_i (ofs.q),
    .stb_o(),
    .out_o(rnd_q)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      dac_stb_o <= 1'b0;
      dac_o     <= '0;
    end else begin
      dac_stb_o <= rnd_stb;
      if (rnd_stb) begin
        dac_o.i <= sel_rail(cfg.mux_i, rnd_i, rnd_q);
        dac_o.q <= sel_rail(cfg.mux_q, rnd_i, rnd_q);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/tx_frontend_pkg.sv
//////////////////////////////////////////////////
// tx front end shared types and constants.
// sample, settings and wishbone structs, register map.
//////////////////////////////////////////////////
`default_nettype none

package tx_frontend_pkg;

  // sample path widths.
  localparam int SAMPLE_W = 16;  // dac and input sample width.
  localparam int WORK_W   = 24;  // working width of the correction path.
  localparam int CORR_W   = 18;  // multiplier coefficient width.
  localparam int SEL_W    = 4;
  localparam int ADR_W    = 3;
  localparam int WB_DAT_W = 32;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] i;
    logic signed [SAMPLE_W-1:0] q;
  } iq_sample_t;

  // samples carry 8 fraction bits while they are being corrected.
  typedef struct packed {
    logic signed [WORK_W-1:0] i;
    logic signed [WORK_W-1:0] q;
  } iq_work_t;

  typedef struct packed {
    logic signed [WORK_W-1:0] dc_i;
    logic signed [WORK_W-1:0] dc_q;
    logic signed [CORR_W-1:0] mag;
    logic signed [CORR_W-1:0] phase;
    logic        [SEL_W-1:0]  mux_i;
    logic        [SEL_W-1:0]  mux_q;
  } tx_corr_cfg_t;

  // word addresses of the settings registers.
  localparam logic [ADR_W-1:0] REG_DC_I  = 3'd0;
  localparam logic [ADR_W-1:0] REG_DC_Q  = 3'd1;
  localparam logic [ADR_W-1:0] REG_MAG   = 3'd2;
  localparam logic [ADR_W-1:0] REG_PHASE = 3'd3;
  localparam logic [ADR_W-1:0] REG_MUX   = 3'd4;  // mux_i in 3:0, mux_q in 7:4.

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [ADR_W-1:0]    adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // dac rail selector codes. Any other code drives zero.
  localparam logic [SEL_W-1:0] SEL_I = 4'd0;
  localparam logic [SEL_W-1:0] SEL_Q = 4'd1;

endpackage

`default_nettype wire

// File: verilog/tx_settings_regs.sv
//////////////////////////////////////////////////
// correction settings registers.
// wishbone classic slave with single cycle ack and readback.
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tx_settings_regs (
  input  wire                            clk,
  input  wire                            rst,
  input  tx_frontend_pkg::wb_req_t       wb_i,
  output tx_frontend_pkg::wb_rsp_t       wb_o,
  output tx_frontend_pkg::tx_corr_cfg_t  cfg_o
);

  tx_frontend_pkg::tx_corr_cfg_t         cfg_q;
  logic                                  ack_q;
  logic [tx_frontend_pkg::WB_DAT_W-1:0]  rdat_q;
  logic [tx_frontend_pkg::WB_DAT_W-1:0]  rdat;
  logic                                  access;

  // a new access is one that has not been acked yet.
  assign access = wb_i.cyc & wb_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      cfg_q <= '0;
    end else begin
      ack_q <= access;  // ack pulses for one cycle and then stays low for at least one.
      if (access && wb_i.we) begin
        case (wb_i.adr)
          tx_frontend_pkg::REG_DC_I:  cfg_q.dc_i  <= wb_i.dat[tx_frontend_pkg::WORK_W-1:0];
          tx_frontend_pkg::REG_DC_Q:  cfg_q.dc_q  <= wb_i.dat[tx_frontend_pkg::WORK_W-1:0];
          tx_frontend_pkg::REG_MAG:   cfg_q.mag   <= wb_i.dat[tx_frontend_pkg::CORR_W-1:0];
          tx_frontend_pkg::REG_PHASE: cfg_q.phase <= wb_i.dat[tx_frontend_pkg::CORR_W-1:0];
          tx_frontend_pkg::REG_MUX: begin
            cfg_q.mux_i <= wb_i.dat[3:0];
            cfg_q.mux_q <= wb_i.dat[7:4];
          end
          default: ;  // writes to unmapped words are dropped.
        endcase
      end
    end
  end

  // readback is zero extended and unmapped words read zero.
  always_comb begin
    rdat = '0;
    case (wb_i.adr)
      tx_frontend_pkg::REG_DC_I:  rdat[tx_frontend_pkg::WORK_W-1:0] = cfg_q.dc_i;
      tx_frontend_pkg::REG_DC_Q:  rdat[tx_frontend_pkg::WORK_W-1:0] = cfg_q.dc_q;
      tx_frontend_pkg::REG_MAG:   rdat[tx_frontend_pkg::CORR_W-1:0] = cfg_q.mag;
      tx_frontend_pkg::REG_PHASE: rdat[tx_frontend_pkg::CORR_W-1:0] = cfg_q.phase;
      tx_frontend_pkg::REG_MUX: begin
        rdat[3:0] = cfg_q.mux_i;
        rdat[7:4] = cfg_q.mux_q;
      end
      default: rdat = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (access) begin
      rdat_q <= rdat;  // presented together with ack.
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdat_q;
  assign cfg_o    = cfg_q;

  // ack may only answer a request that the master still holds.
  ack_needs_req: assert property (
    @(posedge clk) disable iff (rst)
    $rose(ack_q) |-> wb_i.cyc && wb_i.stb
  );

endmodule

`default_nettype wire
